// ==== bench/fibEngine_trace.txt ====
# kind addr data expdata expresp, hex; T lines give test number and name
# W write, R read, P poll STATUS until done; expdata xxxxxxxx is don't care
T 1 reset_values
R 08 00000000 00000000 0
R 0C 00000000 00000000 0
R 04 00000000 00000000 0
T 2 short_runs
W 04 00000001 00000000 0
W 00 00000001 00000000 0
P 08 00000000 00000002 0
R 0C 00000000 00000001 0
W 04 00000002 00000000 0
W 00 00000001 00000000 0
P 08 00000000 00000002 0
R 0C 00000000 00000001 0
W 04 0000000A 00000000 0
W 00 00000001 00000000 0
P 08 00000000 00000002 0
R 0C 00000000 00000037 0
T 3 overflow
W 04 00000018 00000000 0
W 00 00000001 00000000 0
P 08 00000000 00000002 0
R 0C 00000000 0000B520 0
W 04 00000019 00000000 0
W 00 00000001 00000000 0
P 08 00000000 00000006 0
R 0C 00000000 00002511 0
W 04 00000005 00000000 0
W 00 00000001 00000000 0
P 08 00000000 00000002 0
R 0C 00000000 00000005 0
T 4 zero_count
W 04 00000000 00000000 0
W 00 00000001 00000000 0
R 08 00000000 00000002 0
R 04 00000000 00000000 0
T 5 bus_errors
W 20 12345678 00000000 2
R 20 00000000 xxxxxxxx 2
W 08 FFFFFFFF 00000000 0
R 08 00000000 00000002 0
W 0C 0000FFFF 00000000 0
R 0C 00000000 00000005 0
T 6 stalled_runs
W 04 0000000A 00000000 0
W 00 00000001 00000000 0
P 08 00000000 00000002 0
R 0C 00000000 00000037 0
W 04 00000019 00000000 0
W 00 00000001 00000000 0
P 08 00000000 00000006 0
R 0C 00000000 00002511 0
R 04 00000000 00000019 0

// ==== fibEngine.f ====
+incdir+design
design/fibBusPkg.sv
design/fibCtrlPkg.sv
design/regFile.sv
design/fibDatapath.sv
design/fibController.sv
design/hostRegs.sv
design/fibEngine.sv
bench/clockGen.sv
bench/fibEngineTb.sv

// ==== bench/fibEngineTb.sv ====
`timescale 1ns/100ps
`include "fib_defines.svh"

module fibEngineTb import fibBusPkg::*; ();

    // handshake and poll limits in clock cycles
    localparam int waitLimit = 20;
    localparam int pollLimit = 500;

    logic        clk;
    logic        reset;
    axiLiteReq_t req;
    axiLiteRsp_t rsp;

    integer seed;
    int     cycleCount = 0;
    int     checkCount = 0;
    int     errorCount = 0;
    int     testErrors = 0;
    int     testsRun = 0;
    int     testsFailed = 0;
    int     testNum = 0;
    string  testName = "";
    bit     aborted = 1'b0;

    clockGen clockGen0 (
        .clk   (clk),
        .reset (reset)
    );

    fibEngine dut0 (
        .clk    (clk),
        .reset  (reset),
        .bus    (req),
        .busRsp (rsp)
    );

    // elapsed time for the status poll
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    ////////////////////////////////////////
    // checks and reporting
    ////////////////////////////////////////
    task automatic checkValue(input string name, input busAddr_t addr,
                              input busData_t got, input busData_t exp);
        checkCount++;
        assert (got === exp) else begin
            $display("ERROR %s @%02h: got %08h expected %08h", name, addr, got, exp);
            errorCount++;
            testErrors++;
        end
    endtask

    // a lost handshake ends the run
    task automatic reportTimeout(input string what);
        $display("timeout while waiting for %s", what);
        errorCount++;
        testErrors++;
        aborted = 1'b1;
    endtask

    task automatic reportStall(input string what);
        $display("%s changed or dropped while the master stalled", what);
        errorCount++;
        testErrors++;
    endtask

    task automatic finishTest();
        if (testNum > 0) begin
            testsRun++;
            if (testErrors != 0) begin
                testsFailed++;
            end
            $display("test %0d %s: %s (%0d errors)", testNum, testName,
                     (testErrors == 0) ? "ok" : "FAILED", testErrors);
        end
    endtask

    ////////////////////////////////////////
    // AXI4-Lite master
    ////////////////////////////////////////
    task automatic busWrite(input busAddr_t addr, input busData_t data,
                            output axiResp_t resp);
        int       cycles;
        int       stall;
        axiResp_t held;
        resp = RESP_DECERR;
        req.awaddr  <= addr;
        req.awvalid <= 1'b1;
        req.wdata   <= data;
        req.wstrb   <= 4'hf;
        req.wvalid  <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!rsp.awready && !rsp.wready && cycles < waitLimit);
        req.awvalid <= 1'b0;
        req.wvalid  <= 1'b0;
        assert (rsp.awready || rsp.wready) else reportTimeout("AWREADY and WREADY");
        if (aborted) return;
        // address and data are taken on the same edge
        checkValue("awready", addr, busData_t'(rsp.awready), busData_t'(1));
        checkValue("wready", addr, busData_t'(rsp.wready), busData_t'(1));
        // response one cycle after acceptance
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!rsp.bvalid && cycles < waitLimit);
        assert (rsp.bvalid) else reportTimeout("BVALID");
        if (aborted) return;
        held  = rsp.bresp;
        // back-pressure on B for 0 to 3 cycles
        stall = {$random(seed)} % 4;
        repeat (stall) begin
            @(posedge clk);
            assert (rsp.bvalid && rsp.bresp == held) else reportStall("write response");
        end
        req.bready <= 1'b1;
        @(posedge clk);
        req.bready <= 1'b0;
        resp = held;
    endtask

    task automatic busRead(input busAddr_t addr, output busData_t data,
                           output axiResp_t resp);
        int       cycles;
        int       stall;
        busData_t heldData;
        axiResp_t heldResp;
        data = '0;
        resp = RESP_DECERR;
        req.araddr  <= addr;
        req.arvalid <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!rsp.arready && cycles < waitLimit);
        req.arvalid <= 1'b0;
        assert (rsp.arready) else reportTimeout("ARREADY");
        if (aborted) return;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!rsp.rvalid && cycles < waitLimit);
        assert (rsp.rvalid) else reportTimeout("RVALID");
        if (aborted) return;
        heldData = rsp.rdata;
        heldResp = rsp.rresp;
        // data must hold under back-pressure on R
        stall = {$random(seed)} % 4;
        repeat (stall) begin
            @(posedge clk);
            assert (rsp.rvalid && rsp.rdata == heldData && rsp.rresp == heldResp)
                else reportStall("read response");
        end
        req.rready <= 1'b1;
        @(posedge clk);
        req.rready <= 1'b0;
        data = heldData;
        resp = heldResp;
    endtask

    // read STATUS until the run reports done
    task automatic pollDone(input busAddr_t addr, output busData_t data,
                            output axiResp_t resp);
        int startCycle;
        startCycle = cycleCount;
        do begin
            busRead(addr, data, resp);
        end while (!aborted && !data[`FIB_ST_DONE] && (cycleCount - startCycle) < pollLimit);
        if (!aborted) begin
            assert (data[`FIB_ST_DONE]) else reportTimeout("done in STATUS");
        end
    endtask

    ////////////////////////////////////////
    // trace player
    ////////////////////////////////////////
    initial begin
        int       fd;
        int       fields;
        int       cycles;
        int       expResp;
        string    line;
        string    kind;
        busAddr_t addr;
        busData_t data;
        busData_t expData;
        busData_t gotData;
        axiResp_t gotResp;

        req  = '0;
        seed = 32'hfbfd;
        fd   = $fopen("bench/fibEngine_trace.txt", "r");
        assert (fd != 0) else begin
            $display("could not open the trace file");
            errorCount++;
            aborted = 1'b1;
        end

        // hold off until reset is released
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (reset && cycles < waitLimit);
        assert (!reset) else reportTimeout("reset release");

        while (!aborted && !$feof(fd)) begin
            line   = "";
            void'($fgets(line, fd));
            fields = $sscanf(line, "%s %h %h %h %h", kind, addr, data, expData, expResp);
            // blank lines and comments
            if (fields < 1 || kind[0] == "#") begin
                continue;
            end
            case (kind)
                "T": begin
                    finishTest();
                    void'($sscanf(line, "%s %d %s", kind, testNum, testName));
                    testErrors = 0;
                end
                "W": begin
                    busWrite(addr, data, gotResp);
                    if (!aborted) begin
                        checkValue("bresp", addr, busData_t'(gotResp), busData_t'(expResp));
                    end
                end
                "R": begin
                    busRead(addr, gotData, gotResp);
                    if (!aborted) begin
                        // x in the trace means data is don't care
                        if (!$isunknown(expData)) begin
                            checkValue("rdata", addr, gotData, expData);
                        end
                        checkValue("rresp", addr, busData_t'(gotResp), busData_t'(expResp));
                    end
                end
                "P": begin
                    pollDone(addr, gotData, gotResp);
                    if (!aborted) begin
                        checkValue("status", addr, gotData, expData);
                        checkValue("rresp", addr, busData_t'(gotResp), busData_t'(expResp));
                    end
                end
                default: begin
                    $display("unknown line in the trace: %s", line);
                    errorCount++;
                    testErrors++;
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        finishTest();
        $display("summary: %0d tests, %0d failing, %0d checks, %0d errors",
                 testsRun, testsFailed, checkCount, errorCount);
        if (errorCount == 0 && testsRun > 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== bench/clockGen.sv ====
`timescale 1ns/100ps

module clockGen #(
    parameter int halfPeriod  = 20,
    parameter int resetCycles = 2
) (
    output logic clk,
    output logic reset
);

    // free running, 40 ns period
    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk;
    end

    // synchronous reset, held over the first edges
    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== design/fibEngine.sv ====
`timescale 1ns/100ps

module fibEngine import fibBusPkg::*, fibCtrlPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  axiLiteReq_t bus,
    output axiLiteRsp_t busRsp
);

    // host side
    logic       startPulse;
    termCount_t termCount;
    logic       busy;
    logic       done;
    logic       overflow;
    dataWord_t  lastTerm;

    // engine side
    ctrlWord_t  ctrl;
    dataWord_t  readData1;
    dataWord_t  readData2;
    dataWord_t  writeData;
    logic       carry;

    ////////////////////////////////////////
    // host register block
    ////////////////////////////////////////
    hostRegs hostRegs0 (
        .clk        (clk),
        .reset      (reset),
        .bus        (bus),
        .busRsp     (busRsp),
        .startPulse (startPulse),
        .termCount  (termCount),
        .busy       (busy),
        .done       (done),
        .overflow   (overflow),
        .lastTerm   (lastTerm)
    );

    ////////////////////////////////////////
    // engine
    ////////////////////////////////////////
    fibController fibController0 (
        .clk        (clk),
        .reset      (reset),
        .startPulse (startPulse),
        .termCount  (termCount),
        .carry      (carry),
        .ctrl       (ctrl),
        .busy       (busy),
        .done       (done),
        .overflow   (overflow)
    );

    // indices and write enable straight from the control word
    regFile regFile0 (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .writeData (writeData),
        .readData1 (readData1),
        .readData2 (readData2)
    );

    fibDatapath fibDatapath0 (
        .clk       (clk),
        .reset     (reset),
        .aluOp     (ctrl.aluOp),
        .readData1 (readData1),
        .readData2 (readData2),
        .writeData (writeData),
        .carry     (carry),
        .lastTerm  (lastTerm)
    );

endmodule

// ==== design/hostRegs.sv ====
`timescale 1ns/100ps
`include "fib_defines.svh"

module hostRegs import fibBusPkg::*, fibCtrlPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  axiLiteReq_t bus,
    output axiLiteRsp_t busRsp,
    output logic        startPulse,
    output termCount_t  termCount,
    input  logic        busy,
    input  logic        done,
    input  logic        overflow,
    input  dataWord_t   lastTerm
);

    logic     wrAccept;
    logic     rdAccept;
    logic     bValid;
    logic     rValid;
    axiResp_t bResp;
    axiResp_t rResp;
    busData_t rData;
    busData_t statusWord;
    busData_t readMux;
    axiResp_t readErr;

    ////////////////////////////////////////
    // write channel
    ////////////////////////////////////////

    // address and data taken together, one outstanding response
    assign wrAccept = bus.awvalid && bus.wvalid && !bValid;

    // start request, pulse on the accept cycle
    assign startPulse = wrAccept && (bus.awaddr == `FIB_ADDR_CTRL)
                        && bus.wstrb[0] && bus.wdata[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            bValid    <= 1'b0;
            termCount <= '0;
        end else begin
            if (wrAccept) begin
                bValid <= 1'b1;
            end else if (bus.bready) begin
                bValid <= 1'b0;
            end
            // only COUNT is stored, CTRL is a strobe
            if (wrAccept && (bus.awaddr == `FIB_ADDR_COUNT) && bus.wstrb[0]) begin
                termCount <= bus.wdata[`FIB_CNT_W-1:0];
            end
        end
    end

    // status and result writes are dropped but still OKAY
    always_ff @(posedge clk) begin
        if (wrAccept) begin
            case (bus.awaddr)
                `FIB_ADDR_CTRL, `FIB_ADDR_COUNT,
                `FIB_ADDR_STATUS, `FIB_ADDR_RESULT: bResp <= RESP_OKAY;
                default: bResp <= RESP_SLVERR;
            endcase
        end
    end

    ////////////////////////////////////////
    // read channel
    ////////////////////////////////////////
    assign rdAccept = bus.arvalid && !rValid;

    always_comb begin
        statusWord                = '0;
        statusWord[`FIB_ST_BUSY] = busy;
        statusWord[`FIB_ST_DONE] = done;
        statusWord[`FIB_ST_OVF]  = overflow;
    end

    // register map decode
    always_comb begin
        readMux = '0;
        readErr = RESP_OKAY;
        case (bus.araddr)
            // CTRL has no stored bits
            `FIB_ADDR_CTRL:   readMux = '0;
            `FIB_ADDR_COUNT:  readMux = busData_t'(termCount);
            `FIB_ADDR_STATUS: readMux = statusWord;
            `FIB_ADDR_RESULT: readMux = busData_t'(lastTerm);
            default:          readErr = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rValid <= 1'b0;
        end else if (rdAccept) begin
            rValid <= 1'b1;
        end else if (bus.rready) begin
            rValid <= 1'b0;
        end
    end

    // held stable until the master takes it
    always_ff @(posedge clk) begin
        if (rdAccept) begin
            rData <= readMux;
            rResp <= readErr;
        end
    end

    ////////////////////////////////////////
    // response bundle
    ////////////////////////////////////////
    assign busRsp.awready = wrAccept;
    assign busRsp.wready  = wrAccept;
    assign busRsp.bresp   = bResp;
    assign busRsp.bvalid  = bValid;
    assign busRsp.arready = rdAccept;
    assign busRsp.rdata   = rData;
    assign busRsp.rresp   = rResp;
    assign busRsp.rvalid  = rValid;

endmodule

// ==== design/fibController.sv ====
`timescale 1ns/100ps

module fibController import fibCtrlPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       startPulse,
    input  termCount_t termCount,
    input  logic       carry,
    output ctrlWord_t  ctrl,
    output logic       busy,
    output logic       done,
    output logic       overflow
);

    ctrlState_t state;
    ctrlState_t nextState;
    termCount_t termsLeft;
    logic       runStart;
    logic       lastWrite;

    // start only from idle with something to do
    assign runStart  = (state == IDLE) && startPulse && (termCount != '0);
    // the write in this cycle is the final term
    assign lastWrite = (state != IDLE) && (termsLeft == termCount_t'(1));

    ////////////////////////////////////////
    // state sequencing
    ////////////////////////////////////////
    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (runStart) begin
                    nextState = LOAD0;
                end
            end
            LOAD0: nextState = LOAD1;
            LOAD1: nextState = ADD10;
            ADD10: nextState = ADD01;
            ADD01: nextState = ADD10;
            default: nextState = IDLE;
        endcase
        // count reached, back to idle from any step
        if (lastWrite) begin
            nextState = IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            termsLeft <= '0;
            busy      <= 1'b0;
            done      <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            state <= nextState;
            if (runStart) begin
                // latch N so host writes to COUNT mid-run do no harm
                termsLeft <= termCount;
                busy      <= 1'b1;
                done      <= 1'b0;
                overflow  <= 1'b0;
            end else if (state != IDLE) begin
                termsLeft <= termsLeft - 1'b1;
                // sticky over the whole run
                overflow  <= overflow | carry;
                if (lastWrite) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // control word per step
    ////////////////////////////////////////
    always_comb begin
        ctrl = '0;
        case (state)
            // mov R0, 1
            LOAD0: begin
                ctrl.writeEn  = 1'b1;
                ctrl.writeSel = regIdx_t'(0);
                ctrl.aluOp    = OP_ONE;
            end
            // mov R1, 1
            LOAD1: begin
                ctrl.writeEn  = 1'b1;
                ctrl.writeSel = regIdx_t'(1);
                ctrl.aluOp    = OP_ONE;
            end
            // add R1, R0
            ADD10: begin
                ctrl.writeEn  = 1'b1;
                ctrl.writeSel = regIdx_t'(1);
                ctrl.read1    = regIdx_t'(0);
                ctrl.read2    = regIdx_t'(1);
                ctrl.aluOp    = OP_ADD;
            end
            // add R0, R1
            ADD01: begin
                ctrl.writeEn  = 1'b1;
                ctrl.writeSel = regIdx_t'(0);
                ctrl.read1    = regIdx_t'(1);
                ctrl.read2    = regIdx_t'(0);
                ctrl.aluOp    = OP_ADD;
            end
            default: ctrl.aluOp = OP_NOP;
        endcase
    end

endmodule

// ==== design/fibDatapath.sv ====
`timescale 1ns/100ps
`include "fib_defines.svh"

module fibDatapath import fibCtrlPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  aluOp_t    aluOp,
    input  dataWord_t readData1,
    input  dataWord_t readData2,
    output dataWord_t writeData,
    output logic      carry,
    output dataWord_t lastTerm
);

    // one extra bit for the carry out of bit 15
    logic [`FIB_DATA_W:0] sum;

    assign sum = {1'b0, readData1} + {1'b0, readData2};

    ////////////////////////////////////////
    // ALU and source select
    ////////////////////////////////////////
    always_comb begin
        writeData = '0;
        carry     = 1'b0;
        case (aluOp)
            // seed value for R0 and R1
            OP_ONE: writeData = dataWord_t'(1);
            OP_ADD: begin
                writeData = sum[`FIB_DATA_W-1:0];
                carry     = sum[`FIB_DATA_W];
            end
            default: begin
                writeData = '0;
                carry     = 1'b0;
            end
        endcase
    end

    // follows every write into the register file
    always_ff @(posedge clk) begin
        if (reset) begin
            lastTerm <= '0;
        end else if (aluOp != OP_NOP) begin
            lastTerm <= writeData;
        end
    end

endmodule

// ==== design/regFile.sv ====
`timescale 1ns/100ps
`include "fib_defines.svh"

module regFile import fibCtrlPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  ctrlWord_t ctrl,
    input  dataWord_t writeData,
    output dataWord_t readData1,
    output dataWord_t readData2
);

    // sixteen general registers
    dataWord_t regs [`FIB_REG_N];

    ////////////////////////////////////////
    // write port
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `FIB_REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.writeEn) begin
            regs[ctrl.writeSel] <= writeData;
        end
    end

    ////////////////////////////////////////
    // read ports
    ////////////////////////////////////////

    // async, same-cycle write not visible yet
    assign readData1 = regs[ctrl.read1];
    assign readData2 = regs[ctrl.read2];

endmodule

// ==== design/fibCtrlPkg.sv ====
`include "fib_defines.svh"

package fibCtrlPkg;

    // one fibonacci term
    typedef logic [`FIB_DATA_W-1:0] dataWord_t;

    // register file index, R0..R15
    typedef logic [$clog2(`FIB_REG_N)-1:0] regIdx_t;

    // number of terms per run
    typedef logic [`FIB_CNT_W-1:0] termCount_t;

    // what the ALU puts on the write bus
    typedef enum logic [1:0] {
        OP_NOP = 2'd0,
        OP_ONE = 2'd1,
        OP_ADD = 2'd2
    } aluOp_t;

    // run sequence, add states alternate
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        LOAD0 = 3'd1,
        LOAD1 = 3'd2,
        ADD10 = 3'd3,
        ADD01 = 3'd4
    } ctrlState_t;

    // one step of the engine
    typedef struct packed {
        logic    writeEn;
        regIdx_t writeSel;
        regIdx_t read1;
        regIdx_t read2;
        aluOp_t  aluOp;
    } ctrlWord_t;

endpackage

// ==== design/fibBusPkg.sv ====
package fibBusPkg;

    // host side address and data
    typedef logic [7:0]  busAddr_t;
    typedef logic [31:0] busData_t;

    // standard AXI response codes
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axiResp_t;

    ////////////////////////////////////////
    // master to slave
    ////////////////////////////////////////
    typedef struct packed {
        busAddr_t   awaddr;
        logic       awvalid;
        busData_t   wdata;
        logic [3:0] wstrb;
        logic       wvalid;
        logic       bready;
        busAddr_t   araddr;
        logic       arvalid;
        logic       rready;
    } axiLiteReq_t;

    ////////////////////////////////////////
    // slave to master
    ////////////////////////////////////////
    typedef struct packed {
        logic     awready;
        logic     wready;
        axiResp_t bresp;
        logic     bvalid;
        logic     arready;
        busData_t rdata;
        axiResp_t rresp;
        logic     rvalid;
    } axiLiteRsp_t;

endpackage

// ==== design/fib_defines.svh ====
`ifndef FIB_DEFINES_SVH
`define FIB_DEFINES_SVH

// engine sizes
`define FIB_DATA_W 16
`define FIB_REG_N  16
`define FIB_CNT_W  8

////////////////////////////////////////
// host register map
////////////////////////////////////////

// byte addresses on the host bus
`define FIB_ADDR_CTRL   8'h00
`define FIB_ADDR_COUNT  8'h04
`define FIB_ADDR_STATUS 8'h08
`define FIB_ADDR_RESULT 8'h0C

// status word bits
`define FIB_ST_BUSY 0
`define FIB_ST_DONE 1
`define FIB_ST_OVF  2

`endif
